// File: source/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	////////////////////////////////////////
	// Basic types
	////////////////////////////////////////

	typedef logic [7:0]  lcd_byte_t;  // Char code or instruction byte
	typedef logic [15:0] lcd_ticks_t; // Interval length in clk cycles

	// Host command levels, listed from highest priority down
	typedef struct packed {
		logic      reset;      // Function set, 8-bit interface wake up
		logic      set;        // Function set, 8-bit and two lines
		logic      clear;      // Clear display
		logic      off;        // Display off
		logic      on;         // Display on, no cursor
		logic      entry_mode; // Increment, no shift
		logic      cursor;     // Move to DDRAM address
		logic      w_char;     // Write one character
		lcd_byte_t cursor_pos; // DDRAM address for cursor
		lcd_byte_t ascii_char; // Char for w_char
	} lcd_cmd_t;

	// Pins toward the panel
	typedef struct packed {
		logic      rs;   // Low for instruction, high for data
		logic      e;    // Enable strobe
		lcd_byte_t data;
	} lcd_bus_t;

	// Sequencer states
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0, // Waiting for a command level
		ST_SETUP = 3'd1, // rs and data settle before e
		ST_PULSE = 3'd2, // e high
		ST_HOLD  = 3'd3, // Data held after e falls
		ST_EXEC  = 3'd4  // Panel executes the instruction
	} lcd_state_t;

	////////////////////////////////////////
	// Instruction codes
	////////////////////////////////////////

	localparam lcd_byte_t INS_FUNC_RESET = 8'h30; // 8-bit bus, sent on wake up
	localparam lcd_byte_t INS_FUNC_SET   = 8'h38; // 8-bit bus, two lines, 5x8 font
	localparam lcd_byte_t INS_CLEAR      = 8'h01;
	localparam lcd_byte_t INS_DISP_OFF   = 8'h08;
	localparam lcd_byte_t INS_DISP_ON    = 8'h0C; // Cursor and blink off
	localparam lcd_byte_t INS_ENTRY      = 8'h06; // Address increments
	localparam lcd_byte_t INS_DDRAM      = 8'h80; // OR the address in

	////////////////////////////////////////
	// Protocol timing, simulation sized
	////////////////////////////////////////

	localparam lcd_ticks_t T_SETUP     = 16'd2;  // rs/data to e rise
	localparam lcd_ticks_t T_PULSE     = 16'd4;  // e high width
	localparam lcd_ticks_t T_HOLD      = 16'd2;  // e fall to end of data
	localparam lcd_ticks_t T_EXEC      = 16'd20; // Most instructions
	localparam lcd_ticks_t T_EXEC_LONG = 16'd80; // Reset and clear

endpackage

`default_nettype wire

// File: source/lcd_cmd_decoder.sv
`default_nettype none

module lcd_cmd_decoder import lcd_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      take,      // Accept pulse from FSM
	input  lcd_cmd_t  cmd,
	output logic      any_cmd,   // Some level is high
	output logic      rs_sel,    // 1 for char write
	output logic      long_wait, // Reset or clear was taken
	output lcd_byte_t bus_byte
);

	lcd_byte_t sel_byte;
	logic      sel_rs;
	logic      sel_long;
	lcd_byte_t byte_q;
	logic      rs_q;
	logic      long_q;

	assign any_cmd = cmd.reset | cmd.set | cmd.clear | cmd.off | cmd.on
		| cmd.entry_mode | cmd.cursor | cmd.w_char;

	////////////////////////////////////////
	// Priority encoder
	////////////////////////////////////////

	always_comb begin
		sel_byte = '0;
		sel_rs   = 1'b0;
		sel_long = 1'b0;
		if (cmd.reset) begin
			sel_byte = INS_FUNC_RESET;
			sel_long = 1'b1; // Slow instruction
		end else if (cmd.set) begin
			sel_byte = INS_FUNC_SET;
		end else if (cmd.clear) begin
			sel_byte = INS_CLEAR;
			sel_long = 1'b1; // Panel clears all DDRAM
		end else if (cmd.off) begin
			sel_byte = INS_DISP_OFF;
		end else if (cmd.on) begin
			sel_byte = INS_DISP_ON;
		end else if (cmd.entry_mode) begin
			sel_byte = INS_ENTRY;
		end else if (cmd.cursor) begin
			sel_byte = INS_DDRAM | cmd.cursor_pos; // Address into DDRAM set
		end else if (cmd.w_char) begin
			sel_byte = cmd.ascii_char;
			sel_rs   = 1'b1; // Data register
		end
	end

	// Capture register, frozen for the whole command
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_q <= '0;
			rs_q   <= 1'b0;
			long_q <= 1'b0;
		end else if (take) begin
			byte_q <= sel_byte;
			rs_q   <= sel_rs;
			long_q <= sel_long;
		end
	end

	// Bypass in the accept cycle so the bus register loads the new byte
	assign bus_byte  = take ? sel_byte : byte_q;
	assign rs_sel    = take ? sel_rs : rs_q;
	assign long_wait = long_q; // Only read in ST_HOLD

endmodule

`default_nettype wire

// File: source/lcd_timer.sv
`default_nettype none

module lcd_timer import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       load,     // Start a new interval
	input  lcd_ticks_t load_val, // Interval length
	output logic       done      // One cycle at zero
);

	lcd_ticks_t cnt;   // Cycles left minus one
	logic       armed; // Interval running

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= '0;
			armed <= 1'b0;
		end else if (load) begin
			cnt   <= load_val - lcd_ticks_t'(1); // Zero falls load_val cycles on
			armed <= 1'b1;
		end else if (armed) begin
			if (cnt == '0) begin
				armed <= 1'b0; // Idle until next load
			end else begin
				cnt <= cnt - lcd_ticks_t'(1);
			end
		end
	end

	// Single pulse, armed drops right after
	assign done = armed && (cnt == '0);

endmodule

`default_nettype wire

// File: source/lcd_seq_fsm.sv
`default_nettype none

module lcd_seq_fsm import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       any_cmd,   // Host wants something
	input  logic       long_wait, // Use the long execution time
	input  logic       done,      // Timer interval over
	output logic       take,      // Decoder capture
	output logic       load,      // Timer load
	output logic       drive_en,  // Bus register loads rs/data
	output logic       e_on,      // e level for the next cycle
	output logic       busy,
	output lcd_ticks_t load_val
);

	lcd_state_t state;
	lcd_state_t state_next;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////
	// Next state and timer loads
	////////////////////////////////////////

	always_comb begin
		state_next = state;
		take       = 1'b0;
		load       = 1'b0;
		load_val   = '0;
		case (state)
			ST_IDLE: begin
				if (any_cmd) begin
					take       = 1'b1; // Accept edge
					load       = 1'b1;
					load_val   = T_SETUP;
					state_next = ST_SETUP;
				end
			end
			ST_SETUP: begin
				if (done) begin
					load       = 1'b1;
					load_val   = T_PULSE;
					state_next = ST_PULSE;
				end
			end
			ST_PULSE: begin
				if (done) begin
					load       = 1'b1;
					load_val   = T_HOLD;
					state_next = ST_HOLD;
				end
			end
			ST_HOLD: begin
				if (done) begin
					load       = 1'b1;
					load_val   = long_wait ? T_EXEC_LONG : T_EXEC; // Reset and clear are slow
					state_next = ST_EXEC;
				end
			end
			ST_EXEC: begin
				if (done) begin
					state_next = ST_IDLE; // Levels seen again next cycle
				end
			end
			default: begin
				state_next = ST_IDLE; // Unused codes recover
			end
		endcase
	end

	assign drive_en = take; // rs/data change with busy rise

	// e register follows, so e lines up with ST_PULSE
	assign e_on = (state_next == ST_PULSE);

	assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: source/lcd_bus_driver.sv
`default_nettype none

module lcd_bus_driver import lcd_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      drive_en, // Load new rs/data
	input  logic      e_on,     // e level, one cycle early
	input  logic      rs_sel,
	input  lcd_byte_t bus_byte,
	output lcd_bus_t  bus
);

	////////////////////////////////////////
	// Pin registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus <= '0;
		end else begin
			bus.e <= e_on; // Strobe straight from a flop, no decode glitches on the pin
			if (drive_en) begin
				bus.rs   <= rs_sel;   // Held across the whole command
				bus.data <= bus_byte; // and kept until the next one
			end
		end
	end

endmodule

`default_nettype wire

// File: source/lcd_ctrl.sv
`default_nettype none

module lcd_ctrl import lcd_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      reset,      // Host command levels
	input  logic      set,
	input  logic      clear,
	input  logic      off,
	input  logic      on,
	input  logic      entry_mode,
	input  logic      cursor,
	input  logic      w_char,
	input  lcd_byte_t cursor_pos, // Used with cursor
	input  lcd_byte_t ascii_char, // Used with w_char
	output logic      rs,
	output logic      e,
	output logic      busy,
	output lcd_byte_t data
);

	lcd_cmd_t   cmd;
	lcd_bus_t   bus;
	lcd_byte_t  bus_byte;
	lcd_ticks_t load_val;
	logic       any_cmd;
	logic       take;
	logic       rs_sel;
	logic       long_wait;
	logic       load;
	logic       done;
	logic       drive_en;
	logic       e_on;

	////////////////////////////////////////
	// Host levels into one command word
	////////////////////////////////////////

	assign cmd = '{
		reset:      reset,
		set:        set,
		clear:      clear,
		off:        off,
		on:         on,
		entry_mode: entry_mode,
		cursor:     cursor,
		w_char:     w_char,
		cursor_pos: cursor_pos,
		ascii_char: ascii_char
	};

	lcd_cmd_decoder lcd_cmd_decoder_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.take      (take),
		.cmd       (cmd),
		.any_cmd   (any_cmd),
		.rs_sel    (rs_sel),
		.long_wait (long_wait),
		.bus_byte  (bus_byte)
	);

	lcd_seq_fsm lcd_seq_fsm_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.any_cmd   (any_cmd),
		.long_wait (long_wait),
		.done      (done),
		.take      (take),
		.load      (load),
		.drive_en  (drive_en),
		.e_on      (e_on),
		.busy      (busy),
		.load_val  (load_val)
	);

	lcd_timer lcd_timer_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.load     (load),
		.load_val (load_val),
		.done     (done)
	);

	lcd_bus_driver lcd_bus_driver_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.drive_en (drive_en),
		.e_on     (e_on),
		.rs_sel   (rs_sel),
		.bus_byte (bus_byte),
		.bus      (bus)
	);

	// Panel pins
	assign rs   = bus.rs;
	assign e    = bus.e;
	assign data = bus.data;

endmodule

`default_nettype wire

// File: dv/lcd_assertions.sv
`default_nettype none

module lcd_assertions import lcd_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     take, // FSM accept pulse
	input logic     busy, // High outside ST_IDLE
	input lcd_bus_t bus   // Registered panel pins
);

	int assert_errs = 0; // Failed assertion count

	////////////////////////////////////////
	// Strobe and bus timing
	////////////////////////////////////////

	// Strobe only inside a command
	property e_inside_busy;
		@(posedge clk) disable iff (!arst_n)
		bus.e |-> busy;
	endproperty

	// rs/data already settled when e rises
	property bus_set_before_e;
		@(posedge clk) disable iff (!arst_n)
		$rose(bus.e) |-> $stable({bus.rs, bus.data});
	endproperty

	// No change while e is high, nor right at its fall
	property bus_stable_under_e;
		@(posedge clk) disable iff (!arst_n)
		bus.e |=> $stable({bus.rs, bus.data});
	endproperty

	// Each take opens a fresh busy window, so it only comes from ST_IDLE
	property take_only_idle;
		@(posedge clk) disable iff (!arst_n)
		take |=> $rose(busy);
	endproperty

	e_inside_busy_a: assert property (e_inside_busy)
		else begin
			assert_errs++;
			$error("e high outside busy");
		end
	bus_set_before_e_a: assert property (bus_set_before_e)
		else begin
			assert_errs++;
			$error("bus moved as e rose");
		end
	bus_stable_under_e_a: assert property (bus_stable_under_e)
		else begin
			assert_errs++;
			$error("bus moved under e");
		end
	take_only_idle_a: assert property (take_only_idle)
		else begin
			assert_errs++;
			$error("take outside ST_IDLE");
		end

endmodule

// Top scope, where FSM outputs and the bus register meet
bind lcd_ctrl lcd_assertions lcd_assertions_i (
	.clk    (clk),
	.arst_n (arst_n),
	.take   (take),
	.busy   (busy),
	.bus    (bus)
);

`default_nettype wire

// File: dv/lcd_monitor.sv
`default_nettype none

module lcd_monitor import lcd_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  lcd_cmd_t host, // Levels as driven into the DUT
	input  lcd_bus_t pins, // rs, e, data from the DUT
	input  logic     busy,
	output int       value_errs,
	output int       timing_errs
);

	// Level vector order, w_char at bit 0 up to reset at bit 7
	string names [8] = '{"w_char", "cursor", "entry_mode", "on", "off", "clear",
		"set", "reset"};

	lcd_cmd_t   last_host;  // Inputs seen at the previous edge
	logic [7:0] lv;
	logic [7:0] seen_alone; // One bit per command
	logic [7:0] seen_combo;
	lcd_byte_t  exp_data;
	logic       exp_rs;
	logic       exp_e;
	logic       last_busy;
	int         win;         // Winning level index, -1 for none
	int         i;
	int         busy_cycles; // Position inside the busy window
	int         exp_len;

	// Instruction table of the HD44780 command set
	function automatic lcd_byte_t code_of(input int w, input lcd_cmd_t c);
		case (w)
			7:       code_of = 8'h30; // Function set on wake up
			6:       code_of = 8'h38; // 8-bit, two lines
			5:       code_of = 8'h01;
			4:       code_of = 8'h08;
			3:       code_of = 8'h0C;
			2:       code_of = 8'h06;
			1:       code_of = 8'h80 | c.cursor_pos; // DDRAM address set
			default: code_of = c.ascii_char;         // Data write
		endcase
	endfunction

	task automatic mismatch(input bit timing, input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		if (timing)
			timing_errs++;
		else
			value_errs++;
		$display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
	endtask

	task check_coverage(output int missing);
		int k;
		missing = 0;
		for (k = 0; k < 8; k++) begin
			if (!seen_alone[k] || !seen_combo[k]) begin
				missing++;
				$display("Command %s was never issued %s", names[k],
					seen_alone[k] ? "together with others" : "on its own");
			end
		end
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			last_host   = '0;
			last_busy   = 1'b0;
			seen_alone  = '0;
			seen_combo  = '0;
			exp_data    = '0; // Pins come out of reset at zero
			exp_rs      = 1'b0;
			busy_cycles = 0;
			exp_len     = 0;
		end else begin
			lv = {last_host.reset, last_host.set, last_host.clear, last_host.off,
				last_host.on, last_host.entry_mode, last_host.cursor, last_host.w_char};
			if (busy && !last_busy) begin // Taken at the previous edge
				win = -1;
				for (i = 0; i < 8; i++) begin
					if (lv[i])
						win = i; // Highest set bit wins
				end
				if (win < 0) begin
					timing_errs++;
					$display("busy rose although no command level was high");
				end
				exp_data = code_of(win, last_host);
				exp_rs   = (win == 0);
				exp_len  = T_SETUP + T_PULSE + T_HOLD
					+ ((win == 7 || win == 5) ? T_EXEC_LONG : T_EXEC); // Reset, clear slow
				if ($countones(lv) == 1)
					seen_alone |= lv;
				else
					seen_combo |= lv;
				busy_cycles = 1;
			end else if (busy) begin
				busy_cycles++;
			end
			if (!busy && last_busy && busy_cycles != exp_len)
				mismatch(1'b1, "busy_len", exp_len, busy_cycles);
			exp_e = busy && busy_cycles > T_SETUP && busy_cycles <= T_SETUP + T_PULSE;
			if (pins.e !== exp_e)
				mismatch(1'b1, "e_pulse", exp_e, pins.e);
			if (pins.data !== exp_data) // Held from busy rise to next command
				mismatch(1'b0, exp_e ? "data_at_e" : "data_held", exp_data, pins.data);
			if (pins.rs !== exp_rs)
				mismatch(1'b0, "rs", exp_rs, pins.rs);
			last_busy = busy;
			last_host = host;
		end
	end

endmodule

`default_nettype wire

// File: dv/lcd_tb.sv
`default_nettype none

module lcd_tb import lcd_pkg::*; ();

	localparam int NUM_CMDS    = 60;
	localparam int JUNK_CYCLES = 10; // Level churn inside each busy window
	localparam int MAX_BUSY    = T_SETUP + T_PULSE + T_HOLD + T_EXEC_LONG;
	localparam int CYCLE_LIMIT = NUM_CMDS * (MAX_BUSY + 4) + 50; // Accept and hand back

	logic        clk;
	logic        arst_n;
	lcd_cmd_t    host; // All host levels and operands
	lcd_bus_t    pins;
	logic        rs;
	logic        e;
	logic        busy;
	lcd_byte_t   data;
	logic [31:0] rng_state;
	int          value_errs;
	int          timing_errs;
	int          cov_errs;
	int          assert_errs;
	int          cycles;
	int          n;

	lcd_ctrl lcd_ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.reset      (host.reset),
		.set        (host.set),
		.clear      (host.clear),
		.off        (host.off),
		.on         (host.on),
		.entry_mode (host.entry_mode),
		.cursor     (host.cursor),
		.w_char     (host.w_char),
		.cursor_pos (host.cursor_pos),
		.ascii_char (host.ascii_char),
		.rs         (rs),
		.e          (e),
		.busy       (busy),
		.data       (data)
	);

	assign pins = {rs, e, data};

	lcd_monitor monitor_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.host        (host),
		.pins        (pins),
		.busy        (busy),
		.value_errs  (value_errs),
		.timing_errs (timing_errs)
	);

	// LCG, upper bits only
	function automatic logic [15:0] draw();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	// Bit 7 is reset down to bit 0 w_char
	task automatic pick_levels(input int idx, output logic [7:0] lv);
		logic [15:0] r;
		int          first;
		r     = draw();
		first = r[2:0];
		if (idx < 8)
			lv = 8'h80 >> idx; // Every command alone once up front
		else if (r[5:4] == 2'd0)
			lv = 8'h01 << first;
		else // At least two levels at once
			lv = r[15:8] | (8'h01 << first) | (8'h01 << ((first + 1 + r[7:6]) % 8));
	endtask

	task automatic run_command(input int idx);
		logic [7:0]  lv;
		logic [15:0] r;
		int          k;
		pick_levels(idx, lv);
		r    = draw();
		host = {lv, r}; // cursor_pos and ascii_char
		@(negedge clk);
		while (!busy)
			@(negedge clk);
		for (k = 0; k < JUNK_CYCLES; k++) begin
			r    = draw();
			host = {r[7:0], r[15:8], r[7:0] ^ 8'h5A}; // Must not reach the bus
			@(negedge clk);
		end
		host = {8'h00, r}; // Levels drop well before busy falls
		while (busy)
			@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the command sequence never finished", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		host      = '0;
		arst_n    = 1'b0;
		rng_state = 32'd70;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		repeat (3) @(negedge clk); // Idle pins checked at zero
		for (n = 0; n < NUM_CMDS; n++)
			run_command(n);
		repeat (4) @(negedge clk);
		monitor_i.check_coverage(cov_errs);
		assert_errs = lcd_ctrl_i.lcd_assertions_i.assert_errs; // Bound checker count
		$display("Errors: value %0d, timing %0d, coverage %0d, assertion %0d", value_errs,
			timing_errs, cov_errs, assert_errs);
		if (value_errs + timing_errs + cov_errs + assert_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/lcd_pkg.sv
source/lcd_cmd_decoder.sv
source/lcd_timer.sv
source/lcd_seq_fsm.sv
source/lcd_bus_driver.sv
source/lcd_ctrl.sv
dv/lcd_assertions.sv
dv/lcd_monitor.sv
dv/lcd_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - source/lcd_pkg.sv
  - source/lcd_cmd_decoder.sv
  - source/lcd_timer.sv
  - source/lcd_seq_fsm.sv
  - source/lcd_bus_driver.sv
  - source/lcd_ctrl.sv
  - target: test
    files:
      - dv/lcd_assertions.sv
      - dv/lcd_monitor.sv
      - dv/lcd_tb.sv
